// ==== design/axi_lite_pkg.sv ====
package axi_lite_pkg;

    // Response codes on rresp and bresp.
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // Slave controller states. One transaction in flight at a time.
    typedef enum logic [1:0] {
        IDLE,        // Both address channels open.
        READ_RESP,   // Waiting on read-back, then on rready.
        WRITE_DATA,  // Address taken, waiting for W beat.
        WRITE_RESP   // Register written, then waiting on bready.
    } bus_state_e;

endpackage

// ==== design/clint_map_pkg.sv ====
package clint_map_pkg;

    localparam int NUM_HARTS = 4;
    localparam int HART_W    = 2;

    // Window placement on the system bus.
    localparam logic [31:0] CLINT_BASE     = 32'h0200_0000;
    localparam int          CLINT_WINDOW_W = 16;

    // Offsets inside the window.
    localparam logic [CLINT_WINDOW_W-1:0] MSIP_OFFSET     = 16'h0000; // 4 bytes per hart.
    localparam logic [CLINT_WINDOW_W-1:0] MTIMECMP_OFFSET = 16'h4000; // 8 bytes per hart.
    localparam logic [CLINT_WINDOW_W-1:0] MTIME_OFFSET    = 16'hBFF8;

    // Size of each per-hart array in bytes.
    localparam logic [CLINT_WINDOW_W-1:0] MSIP_SPAN = CLINT_WINDOW_W'(4 * NUM_HARTS);
    localparam logic [CLINT_WINDOW_W-1:0] CMP_SPAN  = CLINT_WINDOW_W'(8 * NUM_HARTS);

    // Decoded register kind of an access.
    typedef enum logic [2:0] {
        REG_NONE,
        REG_MSIP,
        REG_CMP_LO,
        REG_CMP_HI,
        REG_MTIME_LO,
        REG_MTIME_HI
    } clint_reg_e;

endpackage

// ==== design/clint_bus_slave.sv ====
module clint_bus_slave (
    input  logic                              clk,
    input  logic                              rst,

    input  logic [31:0]                       araddr,
    input  logic                              arvalid,
    output logic                              arready,

    output logic [31:0]                       rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  logic                              rready,

    input  logic [31:0]                       awaddr,
    input  logic                              awvalid,
    output logic                              awready,

    input  logic [31:0]                       wdata,
    input  logic [3:0]                        wstrb,
    input  logic                              wvalid,
    output logic                              wready,

    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  logic                              bready,

    output clint_map_pkg::clint_reg_e         wr_reg,
    output logic [31:0]                       wr_data,
    output logic [3:0]                        wr_strb,
    output logic [clint_map_pkg::NUM_HARTS-1:0] hart_wr_en,
    output logic                              mtime_wr_en,

    output clint_map_pkg::clint_reg_e         rd_reg,
    output logic [clint_map_pkg::HART_W-1:0]  rd_hart,
    input  logic [31:0]                       rd_word
);

    import axi_lite_pkg::*;
    import clint_map_pkg::*;

    bus_state_e                state;
    logic                      rd_stage;
    logic [31:0]               addr_q;
    logic [CLINT_WINDOW_W-1:0] offset;
    logic [CLINT_WINDOW_W-1:0] msip_rel;
    logic [CLINT_WINDOW_W-1:0] cmp_rel;
    logic                      in_window;
    logic                      w_fire;
    clint_reg_e                dec_reg;
    logic [HART_W-1:0]         dec_hart;

    assign in_window = (addr_q[31:CLINT_WINDOW_W] == CLINT_BASE[31:CLINT_WINDOW_W]);
    assign offset    = addr_q[CLINT_WINDOW_W-1:0];
    assign msip_rel  = offset - MSIP_OFFSET;      // Wraps high below the base.
    assign cmp_rel   = offset - MTIMECMP_OFFSET;

    always_comb begin
        dec_reg  = REG_NONE;
        dec_hart = '0;
        if (in_window) begin
            if (msip_rel < MSIP_SPAN) begin
                dec_reg  = REG_MSIP;
                dec_hart = msip_rel[HART_W+1:2];
            end else if (cmp_rel < CMP_SPAN) begin
                dec_reg  = cmp_rel[2] ? REG_CMP_HI : REG_CMP_LO;
                dec_hart = cmp_rel[HART_W+2:3];
            end else if (offset[CLINT_WINDOW_W-1:3] == MTIME_OFFSET[CLINT_WINDOW_W-1:3]) begin
                dec_reg = offset[2] ? REG_MTIME_HI : REG_MTIME_LO;
            end
        end
    end

    // Write strobes live for the W handshake cycle only.
    assign w_fire      = (state == WRITE_DATA) && wvalid && wready;
    assign wr_reg      = dec_reg;
    assign wr_data     = wdata;
    assign wr_strb     = wstrb;
    assign mtime_wr_en = w_fire && (dec_reg == REG_MTIME_LO || dec_reg == REG_MTIME_HI);

    always_comb begin
        hart_wr_en = '0;
        if (w_fire && (dec_reg == REG_MSIP || dec_reg == REG_CMP_LO || dec_reg == REG_CMP_HI))
            hart_wr_en[dec_hart] = 1'b1;
    end

    assign rd_reg  = dec_reg;
    assign rd_hart = dec_hart;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            arready  <= 1'b1;
            awready  <= 1'b1;
            wready   <= 1'b0;
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
            rd_stage <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (arvalid && arready) begin // Read wins a tie.
                        arready  <= 1'b0;
                        awready  <= 1'b0;
                        rd_stage <= 1'b0;
                        state    <= READ_RESP;
                    end else if (awvalid && awready) begin
                        arready <= 1'b0;
                        awready <= 1'b0;
                        wready  <= 1'b1;
                        state   <= WRITE_DATA;
                    end
                end
                READ_RESP: begin
                    if (rvalid) begin
                        if (rready) begin
                            rvalid  <= 1'b0;
                            arready <= 1'b1;
                            awready <= 1'b1;
                            state   <= IDLE;
                        end
                    end else if (rd_stage) begin
                        rvalid <= 1'b1;
                    end else begin
                        rd_stage <= 1'b1; // Mux samples this cycle.
                    end
                end
                WRITE_DATA: begin
                    if (wvalid) begin
                        wready <= 1'b0;
                        state  <= WRITE_RESP;
                    end
                end
                WRITE_RESP: begin
                    if (!bvalid) begin
                        bvalid <= 1'b1;
                    end else if (bready) begin
                        bvalid  <= 1'b0;
                        arready <= 1'b1;
                        awready <= 1'b1;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (arvalid && arready)
                addr_q <= araddr;
            else if (awvalid && awready)
                addr_q <= awaddr;
        end
        if (state == READ_RESP && rd_stage && !rvalid) begin
            rdata <= rd_word;
            rresp <= in_window ? RESP_OKAY : RESP_DECERR;
        end
        if (w_fire)
            bresp <= in_window ? RESP_OKAY : RESP_DECERR;
    end

endmodule

// ==== design/clint_mtime.sv ====
module clint_mtime (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en,
    input  logic        wr_reg,   // High when the upper word is written.
    input  logic [31:0] wr_data,
    input  logic [3:0]  wr_strb,
    output logic [63:0] mtime
);

    logic [31:0] mtime_lo;
    logic [31:0] mtime_hi;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime_lo <= '0;
            mtime_hi <= '0;
        end else if (wr_en) begin
            // Counting pauses for the write cycle.
            for (int b = 0; b < 4; b++) begin
                if (wr_strb[b]) begin
                    if (wr_reg)
                        mtime_hi[8*b +: 8] <= wr_data[8*b +: 8];
                    else
                        mtime_lo[8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end else begin
            mtime_lo <= mtime_lo + 32'd1;
            if (mtime_lo == 32'hFFFF_FFFF)
                mtime_hi <= mtime_hi + 32'd1; // Carry out of low word.
        end
    end

    assign mtime = {mtime_hi, mtime_lo};

endmodule

// ==== design/clint_hart_ctl.sv ====
module clint_hart_ctl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  clint_map_pkg::clint_reg_e wr_reg,
    input  logic [31:0]               wr_data,
    input  logic [3:0]                wr_strb,
    input  logic [63:0]               mtime,
    output logic                      msip_bit,
    output logic [63:0]               mtimecmp,
    output logic                      msip_irq,
    output logic                      mtip_irq
);

    import clint_map_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            msip_bit <= 1'b0;
            mtimecmp <= '1;   // Keeps mtip low out of reset.
            msip_irq <= 1'b0;
            mtip_irq <= 1'b0;
        end else begin
            msip_irq <= msip_bit;
            mtip_irq <= (mtime >= mtimecmp);
            if (wr_en) begin
                case (wr_reg)
                    REG_MSIP: begin
                        if (wr_strb[0])
                            msip_bit <= wr_data[0]; // Upper bits are hardwired zero.
                    end
                    REG_CMP_LO: begin
                        for (int b = 0; b < 4; b++) begin
                            if (wr_strb[b])
                                mtimecmp[8*b +: 8] <= wr_data[8*b +: 8];
                        end
                    end
                    REG_CMP_HI: begin
                        for (int b = 0; b < 4; b++) begin
                            if (wr_strb[b])
                                mtimecmp[32 + 8*b +: 8] <= wr_data[8*b +: 8];
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== design/clint_rdata_mux.sv ====
module clint_rdata_mux (
    input  logic                                     clk,
    input  logic                                     rst,
    input  clint_map_pkg::clint_reg_e                rd_reg,
    input  logic [clint_map_pkg::HART_W-1:0]         rd_hart,
    input  logic [clint_map_pkg::NUM_HARTS-1:0]      msip_all,
    input  logic [clint_map_pkg::NUM_HARTS-1:0][63:0] mtimecmp_all,
    input  logic [63:0]                              mtime,
    output logic [31:0]                              rd_word
);

    import clint_map_pkg::*;

    logic [31:0] sel_word;
    logic [63:0] sel_cmp;

    assign sel_cmp = mtimecmp_all[rd_hart];

    always_comb begin
        case (rd_reg)
            REG_MSIP:     sel_word = {31'b0, msip_all[rd_hart]};
            REG_CMP_LO:   sel_word = sel_cmp[31:0];
            REG_CMP_HI:   sel_word = sel_cmp[63:32];
            REG_MTIME_LO: sel_word = mtime[31:0];
            REG_MTIME_HI: sel_word = mtime[63:32];
            default:      sel_word = '0; // Holes and out-of-window.
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            rd_word <= '0;
        else
            rd_word <= sel_word;
    end

endmodule

// ==== design/clint_top.sv ====
module clint_top (
    input  logic                                clk,
    input  logic                                rst,

    input  logic [31:0]                         araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [31:0]                         rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,

    input  logic [31:0]                         awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [31:0]                         wdata,
    input  logic [3:0]                          wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,

    output logic [clint_map_pkg::NUM_HARTS-1:0] msip_irq,
    output logic [clint_map_pkg::NUM_HARTS-1:0] mtip_irq
);

    import clint_map_pkg::*;

    clint_reg_e                     wr_reg;
    logic [31:0]                    wr_data;
    logic [3:0]                     wr_strb;
    logic [NUM_HARTS-1:0]           hart_wr_en;
    logic                           mtime_wr_en;
    clint_reg_e                     rd_reg;
    logic [HART_W-1:0]              rd_hart;
    logic [31:0]                    rd_word;
    logic [63:0]                    mtime;
    logic [NUM_HARTS-1:0]           msip_all;
    logic [NUM_HARTS-1:0][63:0]     mtimecmp_all;

    clint_bus_slave slave_inst (
        .clk, .rst,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .wr_reg, .wr_data, .wr_strb, .hart_wr_en, .mtime_wr_en,
        .rd_reg, .rd_hart, .rd_word
    );

    clint_mtime mtime_inst (
        .clk, .rst,
        .wr_en   (mtime_wr_en),
        .wr_reg  (wr_reg == REG_MTIME_HI),
        .wr_data,
        .wr_strb,
        .mtime
    );

    for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
        clint_hart_ctl hart_inst (
            .clk, .rst,
            .wr_en    (hart_wr_en[h]),
            .wr_reg,
            .wr_data,
            .wr_strb,
            .mtime,
            .msip_bit (msip_all[h]),
            .mtimecmp (mtimecmp_all[h]),
            .msip_irq (msip_irq[h]),
            .mtip_irq (mtip_irq[h])
        );
    end

    clint_rdata_mux rdata_mux_inst (
        .clk, .rst,
        .rd_reg, .rd_hart,
        .msip_all, .mtimecmp_all, .mtime,
        .rd_word
    );

endmodule

// ==== testbench/clint_sva.sv ====
module clint_sva (
    input logic                                clk,
    input logic                                rst,
    input logic                                arvalid,
    input logic                                arready,
    input logic                                rvalid,
    input logic                                rready,
    input logic [31:0]                         rdata,
    input logic [1:0]                          rresp,
    input logic                                wvalid,
    input logic                                wready,
    input logic                                bvalid,
    input logic                                bready,
    input logic [1:0]                          bresp,
    input logic [clint_map_pkg::NUM_HARTS-1:0] hart_wr_en
);

    int fail_count = 0;   // Read by the testbench at the end.

    // Seen high on the third edge after the AR handshake.
    read_latency: assert property (@(posedge clk) disable iff (rst)
        arvalid && arready |-> ##3 $rose(rvalid))
        else begin
            $error("rvalid did not rise two cycles after the AR handshake");
            fail_count++;
        end

    read_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $error("read response changed before rready");
            fail_count++;
        end

    write_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("write response changed before bready");
            fail_count++;
        end

    read_blocks_ar: assert property (@(posedge clk) disable iff (rst) rvalid |-> !arready)
        else begin
            $error("arready high while a read response is pending");
            fail_count++;
        end

    // A hart strobe only comes with a W beat.
    hart_strobe: assert property (@(posedge clk) disable iff (rst)
        hart_wr_en != '0 |-> $onehot(hart_wr_en) && wvalid && wready)
        else begin
            $error("hart write strobe not one-hot or outside a W handshake");
            fail_count++;
        end

endmodule

bind clint_bus_slave clint_sva clint_sva_inst (.*);

// ==== testbench/clint_checker.sv ====
module clint_checker (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                arready,
    input  logic                                awready,
    input  logic                                wready,
    input  logic [31:0]                         rdata,
    input  logic [1:0]                          rresp,
    input  logic                                rvalid,
    input  logic                                rready,
    input  logic [1:0]                          bresp,
    input  logic                                bvalid,
    input  logic                                bready,
    input  logic [clint_map_pkg::NUM_HARTS-1:0] msip_irq,
    input  logic [clint_map_pkg::NUM_HARTS-1:0] mtip_irq,
    input  logic                                chk_valid,
    input  logic                                chk_read,
    input  logic                                chk_gt,
    input  logic                                chk_below,
    input  logic                                chk_irq,
    input  logic [1:0]                          exp_resp,
    input  logic [31:0]                         exp_data,
    input  int                                  test_id,
    output int                                  test_count,
    output int                                  err_count
);

    import clint_map_pkg::*;

    logic [31:0] got_rdata = '0;
    logic [31:0] prev_word = '0;   // Data of the last read.
    logic [31:0] held_rdata = '0;
    logic [1:0]  got_rresp = '0;
    logic [1:0]  got_bresp = '0;
    logic [1:0]  held_rresp = '0;
    logic [1:0]  held_bresp = '0;
    logic        r_waiting = 1'b0;
    logic        b_waiting = 1'b0;

    initial begin
        test_count = 0;
        err_count = 0;
    end

    task automatic log_error(input string name, input string rel, input logic [31:0] exp,
                             input logic [31:0] got);
        $display("mismatch at %0t: %s expected %s%h got %h", $time, name, rel, exp, got);
        err_count++;
    endtask

    task automatic compare_test();
        int errs_before;
        errs_before = err_count;
        test_count++;
        if (chk_read) begin
            if (got_rresp !== exp_resp)
                log_error("rresp", "", 32'(exp_resp), 32'(got_rresp));
            if (chk_gt && !(got_rdata > prev_word))
                log_error("rdata", "> ", prev_word, got_rdata);
            else if (chk_below && !(got_rdata < exp_data))
                log_error("rdata", "< ", exp_data, got_rdata);
            else if (!chk_gt && !chk_below && got_rdata !== exp_data)
                log_error("rdata", "", exp_data, got_rdata);
            prev_word = got_rdata;
        end else begin
            if (got_bresp !== exp_resp)
                log_error("bresp", "", 32'(exp_resp), 32'(got_bresp));
            if (chk_irq && msip_irq !== exp_data[NUM_HARTS-1:0])
                log_error("msip_irq", "", 32'(exp_data[NUM_HARTS-1:0]), 32'(msip_irq));
            if (chk_irq && mtip_irq !== exp_data[2*NUM_HARTS-1:NUM_HARTS])
                log_error("mtip_irq", "", 32'(exp_data[2*NUM_HARTS-1:NUM_HARTS]), 32'(mtip_irq));
        end
        $display("test %0d %s at %0t %s", test_id, chk_read ? "read" : "write", $time,
                 err_count == errs_before ? "ok" : "bad");
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (r_waiting && rdata !== held_rdata)
                log_error("rdata", "held ", held_rdata, rdata);
            if (r_waiting && rresp !== held_rresp)
                log_error("rresp", "held ", 32'(held_rresp), 32'(rresp));
            if (b_waiting && bresp !== held_bresp)
                log_error("bresp", "held ", 32'(held_bresp), 32'(bresp));
            if ((rvalid || bvalid) && (arready || awready)) begin
                $display("error at %0t: address channel ready while a response is pending",
                         $time);
                err_count++;
            end
            if (wready && (arready || awready || rvalid || bvalid)) begin
                $display("error at %0t: wready high outside the write data phase", $time);
                err_count++;
            end
            r_waiting = rvalid && !rready;
            b_waiting = bvalid && !bready;
            held_rdata = rdata;
            held_rresp = rresp;
            held_bresp = bresp;
            if (rvalid && rready) begin
                got_rdata = rdata;
                got_rresp = rresp;
            end
            if (bvalid && bready)
                got_bresp = bresp;
            if (chk_valid)
                compare_test();
        end
    end

endmodule

// ==== testbench/clint_tb.sv ====
module clint_tb;

    import axi_lite_pkg::*;
    import clint_map_pkg::*;

    typedef enum logic [1:0] {CHK_EXACT, CHK_GT, CHK_BELOW, CHK_IRQ} chk_kind_e;

    typedef struct {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic        rnd;    // Data drawn at run time.
        logic [1:0]  resp;
        logic [31:0] exp;
        chk_kind_e   kind;
    } row_t;

    logic                 clk;
    logic                 rst;
    logic [31:0]          araddr, rdata, awaddr, wdata;
    logic                 arvalid, arready, rvalid, rready;
    logic                 awvalid, awready, wvalid, wready, bvalid, bready;
    logic [1:0]           rresp, bresp;
    logic [3:0]           wstrb;
    logic [NUM_HARTS-1:0] msip_irq, mtip_irq;

    logic        chk_valid = 1'b0;
    logic        chk_read = 1'b0;
    logic        chk_gt = 1'b0;
    logic        chk_below = 1'b0;
    logic        chk_irq = 1'b0;
    logic [1:0]  exp_resp = '0;
    logic [31:0] exp_data = '0;
    logic [31:0] rand_word = '0;
    int          test_id = 0;
    int          test_count, err_count;
    int          cycle_cnt = 0;
    int          max_cycles = 0;
    int          mark_cycle = 0;   // Start of the last mtime write.
    row_t        rows[$];

    clint_top clint_top_inst (.*);

    clint_checker checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (max_cycles > 0 && cycle_cnt > max_cycles) begin
            $display("timeout: no complete run within %0d cycles", max_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] window_addr(input logic [CLINT_WINDOW_W-1:0] offset,
                                                input int index, input int stride);
        return CLINT_BASE + 32'(offset) + 32'(index * stride);
    endfunction

    function automatic logic [31:0] irq_word(input int msip_mask, input int mtip_mask);
        return 32'((mtip_mask << NUM_HARTS) | msip_mask); // mtip above msip.
    endfunction

    task automatic add_row(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic rnd, input logic [1:0] resp,
                           input logic [31:0] exp, input chk_kind_e kind);
        row_t r;
        r = '{wr, addr, data, strb, rnd, resp, exp, kind};
        rows.push_back(r);
    endtask

    // 1'b1 marks a write row, 1'b0 a read row.
    task automatic build_table();
        logic [31:0] cmp_lo;
        logic [31:0] a;
        cmp_lo = 32'h12BB_56DD; // Bytes 0 and 2 taken from AABB_CCDD.
        for (int h = 0; h < NUM_HARTS; h++) begin
            a = window_addr(MSIP_OFFSET, h, 4);
            add_row(1'b1, a, 32'd1, 4'hF, 1'b0, RESP_OKAY, irq_word(1 << h, 0), CHK_IRQ);
            add_row(1'b0, a, 32'd0, 4'h0, 1'b0, RESP_OKAY, 32'd1, CHK_EXACT);
            add_row(1'b1, a, 32'd0, 4'hF, 1'b0, RESP_OKAY, irq_word(0, 0), CHK_IRQ);
        end
        // Hart 1 compare words sit at index 2 and 3.
        a = window_addr(MTIMECMP_OFFSET, 2, 4);
        add_row(1'b1, a, 32'h1234_5678, 4'hF, 1'b0, RESP_OKAY, 32'd0, CHK_EXACT);
        add_row(1'b1, a + 4, 32'h9ABC_DEF0, 4'hF, 1'b0, RESP_OKAY, 32'd0, CHK_EXACT);
        add_row(1'b0, a, 32'd0, 4'h0, 1'b0, RESP_OKAY, 32'h1234_5678, CHK_EXACT);
        add_row(1'b0, a + 4, 32'd0, 4'h0, 1'b0, RESP_OKAY, 32'h9ABC_DEF0, CHK_EXACT);
        add_row(1'b1, a, 32'hAABB_CCDD, 4'b0101, 1'b0, RESP_OKAY, 32'd0, CHK_EXACT);
        add_row(1'b0, a, 32'd0, 4'h0, 1'b0, RESP_OKAY, cmp_lo, CHK_EXACT);
        add_row(1'b1, a + 4, 32'd0, 4'hF, 1'b1, RESP_OKAY, 32'd0, CHK_EXACT);
        add_row(1'b0, a + 4, 32'd0, 4'h0, 1'b1, RESP_OKAY, 32'd0, CHK_EXACT);
        a = window_addr(MTIME_OFFSET, 0, 4);
        add_row(1'b0, a, 32'd0, 4'h0, 1'b0, RESP_OKAY, 32'd0, CHK_BELOW);
        add_row(1'b0, a, 32'd0, 4'h0, 1'b0, RESP_OKAY, 32'd0, CHK_GT);
        add_row(1'b1, a + 4, 32'd5, 4'hF, 1'b0, RESP_OKAY, 32'd0, CHK_EXACT);
        add_row(1'b0, a + 4, 32'd0, 4'h0, 1'b0, RESP_OKAY, 32'd5, CHK_EXACT);
        add_row(1'b1, a + 4, 32'd0, 4'hF, 1'b0, RESP_OKAY, 32'd0, CHK_EXACT);
        add_row(1'b1, a, 32'd0, 4'hF, 1'b0, RESP_OKAY, 32'd0, CHK_EXACT);
        add_row(1'b0, a + 4, 32'd0, 4'h0, 1'b0, RESP_OKAY, 32'd0, CHK_EXACT);
        add_row(1'b0, a, 32'd0, 4'h0, 1'b0, RESP_OKAY, 32'd0, CHK_BELOW);
        a = window_addr(MTIMECMP_OFFSET, 4, 4); // Hart 2.
        add_row(1'b1, a, 32'd0, 4'hF, 1'b0, RESP_OKAY, irq_word(0, 0), CHK_IRQ);
        add_row(1'b1, a + 4, 32'd0, 4'hF, 1'b0, RESP_OKAY, irq_word(0, 1 << 2), CHK_IRQ);
        add_row(1'b1, a + 4, 32'hFFFF_FFFF, 4'hF, 1'b0, RESP_OKAY, irq_word(0, 0), CHK_IRQ);
        add_row(1'b1, a, 32'hFFFF_FFFF, 4'hF, 1'b0, RESP_OKAY, irq_word(0, 0), CHK_IRQ);
        add_row(1'b0, 32'h0300_0000, 32'd0, 4'h0, 1'b0, RESP_DECERR, 32'd0, CHK_EXACT);
        add_row(1'b1, 32'h0300_0000, 32'd1, 4'hF, 1'b0, RESP_DECERR, irq_word(0, 0), CHK_IRQ);
        add_row(1'b1, 32'h0300_4008, 32'd0, 4'hF, 1'b0, RESP_DECERR, 32'd0, CHK_EXACT);
        a = window_addr(MTIMECMP_OFFSET, 2, 4);
        add_row(1'b0, a, 32'd0, 4'h0, 1'b0, RESP_OKAY, cmp_lo, CHK_EXACT);
        a = CLINT_BASE + 32'h8000;
        add_row(1'b0, a, 32'd0, 4'h0, 1'b0, RESP_OKAY, 32'd0, CHK_EXACT);
        add_row(1'b1, a, 32'hFFFF_FFFF, 4'hF, 1'b0, RESP_OKAY, 32'd0, CHK_EXACT);
        add_row(1'b0, a, 32'd0, 4'h0, 1'b0, RESP_OKAY, 32'd0, CHK_EXACT);
        a = window_addr(MSIP_OFFSET, NUM_HARTS, 4); // First hole after the msip array.
        add_row(1'b1, a, 32'd1, 4'hF, 1'b0, RESP_OKAY, irq_word(0, 0), CHK_IRQ);
        add_row(1'b0, a, 32'd0, 4'h0, 1'b0, RESP_OKAY, 32'd0, CHK_EXACT);
    endtask

    task automatic read_bus(input logic [31:0] addr, input int delay);
        araddr = addr;
        arvalid = 1'b1;
        while (!arready)
            step();
        step();
        arvalid = 1'b0;
        while (!rvalid)
            step();
        repeat (delay) step();
        rready = 1'b1;
        step();
        rready = 1'b0;
    endtask

    task automatic write_bus(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int delay);
        awaddr = addr;
        awvalid = 1'b1;
        while (!awready)
            step();
        step();
        awvalid = 1'b0;
        wdata = data;
        wstrb = strb;
        wvalid = 1'b1;
        while (!wready)
            step();
        step();
        wvalid = 1'b0;
        while (!bvalid)
            step();
        repeat (delay) step();
        bready = 1'b1;
        step();
        bready = 1'b0;
    endtask

    task automatic run_row(input int idx);
        row_t        r;
        logic [31:0] data;
        logic [31:0] expv;
        int          delay;
        r = rows[idx];
        data = r.data;
        expv = r.exp;
        delay = $urandom_range(3, 0);
        if (r.wr) begin
            if (r.rnd) begin
                data = $urandom;
                rand_word = data;
            end
            if (r.addr[31:3] == window_addr(MTIME_OFFSET, 0, 4) >> 3)
                mark_cycle = cycle_cnt;
            write_bus(r.addr, data, r.strb, delay);
        end else begin
            read_bus(r.addr, delay);
        end
        if (r.rnd && !r.wr)
            expv = rand_word;
        if (r.kind == CHK_BELOW)
            expv = cycle_cnt - mark_cycle;
        chk_read = !r.wr;
        chk_gt = (r.kind == CHK_GT);
        chk_below = (r.kind == CHK_BELOW);
        chk_irq = (r.kind == CHK_IRQ);
        exp_resp = r.resp;
        exp_data = expv;
        test_id = idx;
        chk_valid = 1'b1;
        step();
        chk_valid = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        void'($urandom(32'hc5d3c0ab));
        build_table();
        max_cycles = rows.size() * 40 + 10;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (rows[i])
            run_row(i);
        $display("%0d tests run, %0d errors, %0d assertion failures", test_count, err_count,
                 clint_top_inst.slave_inst.clint_sva_inst.fail_count);
        if (err_count == 0 && test_count == rows.size()
                && clint_top_inst.slave_inst.clint_sva_inst.fail_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== flist.f ====
design/axi_lite_pkg.sv
design/clint_map_pkg.sv
design/clint_bus_slave.sv
design/clint_mtime.sv
design/clint_hart_ctl.sv
design/clint_rdata_mux.sv
design/clint_top.sv
testbench/clint_sva.sv
testbench/clint_checker.sv
testbench/clint_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the CLINT testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module clint_tb -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vclint_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** PASSED ***' sim.log; then
    exit 0
fi
exit 1
